// File: verilog/rn_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename stage constants
// Lane counts and register index widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RN_CONSTS_SVH
`define RN_CONSTS_SVH

// Instructions renamed per cycle
`define RN_IW 2

// Instructions retired per cycle
`define RN_CW 2

// Physical register index width
`define RN_PRF_AW 6

// Architectural register index width
`define RN_ARF_AW 5

// Physical register count, one per index value
`define RN_N_PRF 64

`endif

// File: verilog/rn_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename stage types
// Register indices and per-lane masks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rn_consts.svh"

package rn_pkg;

   // Index into the physical register file
   typedef logic [`RN_PRF_AW-1:0] prf_idx_t;

   // Architectural register number from decode
   typedef logic [`RN_ARF_AW-1:0] arf_idx_t;

   // One bit per lane
   // Issue and commit widths are equal, so one type serves both
   typedef logic [`RN_IW-1:0] lane_mask_t;

endpackage

`default_nettype wire

// File: verilog/rn_cmt_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Commit bundle from the reorder buffer
// Feeds the free list and the map table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

interface rn_cmt_if ();
   import rn_pkg::*;

   // Lane retires this cycle
   lane_mask_t fire;
   // Retiring instruction wrote a register
   lane_mask_t prd_we;
   // Destination, its physical register and the one it displaced
   arf_idx_t   lrd   [`RN_CW];
   prf_idx_t   prd   [`RN_CW];
   prf_idx_t   pfree [`RN_CW];

   // Filled from the top-level ports
   modport src (output fire, prd_we, lrd, prd, pfree);

   // Free lists only care about physical numbers
   modport fl  (input fire, prd_we, prd, pfree);

   // Architectural map needs the destination too
   modport rat (input fire, prd_we, lrd, prd);

endinterface

`default_nettype wire

// File: verilog/prio_enc_gs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Priority encoder, lowest set bit wins
// gs flags a non-empty input
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

module prio_enc_gs
(
   input  logic [`RN_N_PRF-1:0] din,
   output rn_pkg::prf_idx_t     dout,
   output logic                 gs
);
   import rn_pkg::*;

   // Scan from the top so the lowest hit is the last write
   always_comb
      begin
         dout = '0;
         for (int i = `RN_N_PRF - 1; i >= 0; i--)
            begin
               if (din[i])
                  dout = prf_idx_t'(i);
            end
      end

   // Any bit set
   assign gs = |din;

endmodule

`default_nettype wire

// File: verilog/rn_fl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Physical register free lists, speculative and committed
// Two-lane allocation with stall and rollback restore
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

module rn_fl
(
   input  logic               clk,
   input  logic               rst,
   input  rn_pkg::lane_mask_t pop,
   input  rn_pkg::lane_mask_t lrd_we,
   input  logic               rollback,
   rn_cmt_if.fl               cmt,
   output logic               fl_stall_req,
   output rn_pkg::prf_idx_t   fl_prd [`RN_IW]
);
   import rn_pkg::*;

   localparam int N_ARF = 1 << `RN_ARF_AW;
   // Single-bit mask, shifted to a register number
   localparam logic [`RN_N_PRF-1:0] FL_ONE = {{(`RN_N_PRF-1){1'b0}}, 1'b1};
   // Low registers hold the identity mapping out of reset
   localparam logic [`RN_N_PRF-1:0] FL_RST = {{(`RN_N_PRF-N_ARF){1'b1}}, {N_ARF{1'b0}}};

   // Bit set means the register is free
   logic [`RN_N_PRF-1:0] fl_q;
   logic [`RN_N_PRF-1:0] fl_nxt;
   logic [`RN_N_PRF-1:0] afl_q;
   logic [`RN_N_PRF-1:0] afl_nxt;
   // Lane 1 sees the list minus lane 0's pick
   logic [`RN_N_PRF-1:0] fl_l1;
   prf_idx_t             sel_prd0;
   prf_idx_t             sel_prd1;
   lane_mask_t           gs;

   // Lane 0 pick
   prio_enc_gs u_penc_l0
   (
      .din  (fl_q),
      .dout (sel_prd0),
      .gs   (gs[0])
   );

   // Knock out lane 0's choice even if lane 0 does not write
   assign fl_l1 = fl_q & ~(FL_ONE << sel_prd0);

   // Lane 1 pick
   prio_enc_gs u_penc_l1
   (
      .din  (fl_l1),
      .dout (sel_prd1),
      .gs   (gs[1])
   );

   assign fl_prd[0] = sel_prd0;
   assign fl_prd[1] = sel_prd1;

   // Writer with nothing left to take
   assign fl_stall_req = |(lrd_we & ~gs);

   // Speculative list
   always_comb
      begin
         fl_nxt = fl_q;
         // Allocate accepted destinations
         for (int j = 0; j < `RN_IW; j++)
            begin
               if (pop[j] && lrd_we[j])
                  fl_nxt = fl_nxt & ~(FL_ONE << fl_prd[j]);
            end
         // Displaced mapping is dead once its overwriter retires
         for (int j = 0; j < `RN_CW; j++)
            begin
               if (cmt.fire[j] && cmt.prd_we[j])
                  fl_nxt = fl_nxt | (FL_ONE << cmt.pfree[j]);
            end
      end

   // Architectural list, commits only
   always_comb
      begin
         afl_nxt = afl_q;
         for (int j = 0; j < `RN_CW; j++)
            begin
               if (cmt.fire[j] && cmt.prd_we[j])
                  begin
                     afl_nxt = afl_nxt & ~(FL_ONE << cmt.prd[j]);
                     afl_nxt = afl_nxt | (FL_ONE << cmt.pfree[j]);
                  end
            end
      end

   // Rollback takes the committed copy as it stood before this edge
   always_ff @(posedge clk)
      begin
         if (rst)
            begin
               fl_q  <= FL_RST;
               afl_q <= FL_RST;
            end
         else
            begin
               fl_q  <= rollback ? afl_q : fl_nxt;
               afl_q <= afl_nxt;
            end
      end

endmodule

`default_nettype wire

// File: verilog/rn_rat.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register alias tables, speculative and committed
// Source lookup with lane 0 bypass, rollback restore
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

module rn_rat
(
   input  logic               clk,
   input  logic               rst,
   input  rn_pkg::lane_mask_t pop,
   input  rn_pkg::lane_mask_t lrd_we,
   input  rn_pkg::arf_idx_t   lrd   [`RN_IW],
   input  rn_pkg::arf_idx_t   lrs1  [`RN_IW],
   input  rn_pkg::arf_idx_t   lrs2  [`RN_IW],
   input  rn_pkg::prf_idx_t   prd   [`RN_IW],
   input  logic               rollback,
   rn_cmt_if.rat              cmt,
   output rn_pkg::prf_idx_t   prs1  [`RN_IW],
   output rn_pkg::prf_idx_t   prs2  [`RN_IW],
   output rn_pkg::prf_idx_t   pfree [`RN_IW]
);
   import rn_pkg::*;

   localparam int N_ARF = 1 << `RN_ARF_AW;

   // Speculative map, updated at rename
   prf_idx_t rat_q  [N_ARF];
   // Committed map, updated at retire
   prf_idx_t arat_q [N_ARF];

   // Lane 1 operand matches lane 0's destination
   logic byp_rs1;
   logic byp_rs2;
   logic byp_rd;

   assign byp_rs1 = lrd_we[0] && (lrs1[1] == lrd[0]);
   assign byp_rs2 = lrd_we[0] && (lrs2[1] == lrd[0]);
   assign byp_rd  = lrd_we[0] && (lrd[1] == lrd[0]);

   // Lane 0 reads the table directly
   assign prs1[0]  = rat_q[lrs1[0]];
   assign prs2[0]  = rat_q[lrs2[0]];
   assign pfree[0] = rat_q[lrd[0]];

   // Lane 1 sees lane 0's fresh mapping
   assign prs1[1]  = byp_rs1 ? prd[0] : rat_q[lrs1[1]];
   assign prs2[1]  = byp_rs2 ? prd[0] : rat_q[lrs2[1]];
   // Same destination twice, lane 1 displaces lane 0's register
   assign pfree[1] = byp_rd  ? prd[0] : rat_q[lrd[1]];

   // Speculative table
   always_ff @(posedge clk)
      begin
         if (rst)
            begin
               for (int i = 0; i < N_ARF; i++)
                  rat_q[i] <= prf_idx_t'(i);
            end
         else if (rollback)
            rat_q <= arat_q;
         else
            begin
               // Lane order, so lane 1 wins a shared destination
               for (int j = 0; j < `RN_IW; j++)
                  begin
                     if (pop[j] && lrd_we[j])
                        rat_q[lrd[j]] <= prd[j];
                  end
            end
      end

   // Committed table
   always_ff @(posedge clk)
      begin
         if (rst)
            begin
               for (int i = 0; i < N_ARF; i++)
                  arat_q[i] <= prf_idx_t'(i);
            end
         else
            begin
               // Older lane first
               for (int j = 0; j < `RN_CW; j++)
                  begin
                     if (cmt.fire[j] && cmt.prd_we[j])
                        arat_q[cmt.lrd[j]] <= cmt.prd[j];
                  end
            end
      end

endmodule

`default_nettype wire

// File: verilog/rn_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register rename stage, two lanes
// Free list and alias table behind a valid/stall handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

module rn_top
(
   input  logic                         clk,
   input  logic                         rst,
   // Rename group, lane 0 in the low bits
   input  logic                         in_valid,
   input  logic [`RN_IW-1:0]            in_lrd_we,
   input  logic [`RN_IW*`RN_ARF_AW-1:0] in_lrd,
   input  logic [`RN_IW*`RN_ARF_AW-1:0] in_lrs1,
   input  logic [`RN_IW*`RN_ARF_AW-1:0] in_lrs2,
   output logic                         in_stall,
   // Same-cycle results
   output logic [`RN_IW*`RN_PRF_AW-1:0] out_prd,
   output logic [`RN_IW*`RN_PRF_AW-1:0] out_pfree,
   output logic [`RN_IW*`RN_PRF_AW-1:0] out_prs1,
   output logic [`RN_IW*`RN_PRF_AW-1:0] out_prs2,
   // Reorder buffer side
   input  logic                         rollback,
   input  logic [`RN_CW-1:0]            cmt_fire,
   input  logic [`RN_CW-1:0]            cmt_prd_we,
   input  logic [`RN_CW*`RN_ARF_AW-1:0] cmt_lrd,
   input  logic [`RN_CW*`RN_PRF_AW-1:0] cmt_prd,
   input  logic [`RN_CW*`RN_PRF_AW-1:0] cmt_pfree
);
   import rn_pkg::*;

   lane_mask_t pop;
   logic       fl_stall_req;
   arf_idx_t   lrd   [`RN_IW];
   arf_idx_t   lrs1  [`RN_IW];
   arf_idx_t   lrs2  [`RN_IW];
   prf_idx_t   fl_prd [`RN_IW];
   prf_idx_t   prs1  [`RN_IW];
   prf_idx_t   prs2  [`RN_IW];
   prf_idx_t   pfree [`RN_IW];

   rn_cmt_if cmt_if ();

   // Whole group goes or waits
   assign in_stall = fl_stall_req;
   assign pop      = {`RN_IW{in_valid & ~fl_stall_req}};

   // Unpack issue lanes, pack results
   for (genvar i = 0; i < `RN_IW; i++)
      begin : g_lane
         assign lrd[i]  = in_lrd [i*`RN_ARF_AW +: `RN_ARF_AW];
         assign lrs1[i] = in_lrs1[i*`RN_ARF_AW +: `RN_ARF_AW];
         assign lrs2[i] = in_lrs2[i*`RN_ARF_AW +: `RN_ARF_AW];
         assign out_prd  [i*`RN_PRF_AW +: `RN_PRF_AW] = fl_prd[i];
         assign out_pfree[i*`RN_PRF_AW +: `RN_PRF_AW] = pfree[i];
         assign out_prs1 [i*`RN_PRF_AW +: `RN_PRF_AW] = prs1[i];
         assign out_prs2 [i*`RN_PRF_AW +: `RN_PRF_AW] = prs2[i];
      end

   // Commit bundle
   assign cmt_if.fire   = cmt_fire;
   assign cmt_if.prd_we = cmt_prd_we;
   for (genvar j = 0; j < `RN_CW; j++)
      begin : g_cmt
         assign cmt_if.lrd[j]   = cmt_lrd  [j*`RN_ARF_AW +: `RN_ARF_AW];
         assign cmt_if.prd[j]   = cmt_prd  [j*`RN_PRF_AW +: `RN_PRF_AW];
         assign cmt_if.pfree[j] = cmt_pfree[j*`RN_PRF_AW +: `RN_PRF_AW];
      end

   rn_fl u_fl
   (
      .clk          (clk),
      .rst          (rst),
      .pop          (pop),
      .lrd_we       (in_lrd_we),
      .rollback     (rollback),
      .cmt          (cmt_if.fl),
      .fl_stall_req (fl_stall_req),
      .fl_prd       (fl_prd)
   );

   rn_rat u_rat
   (
      .clk      (clk),
      .rst      (rst),
      .pop      (pop),
      .lrd_we   (in_lrd_we),
      .lrd      (lrd),
      .lrs1     (lrs1),
      .lrs2     (lrs2),
      .prd      (fl_prd),
      .rollback (rollback),
      .cmt      (cmt_if.rat),
      .prs1     (prs1),
      .prs2     (prs2),
      .pfree    (pfree)
   );

endmodule

`default_nettype wire

// File: tests/rn_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename stage properties, bound to the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

module rn_asserts
(
   input logic                         clk,
   input logic                         rst,
   input logic                         in_valid,
   input logic [`RN_IW-1:0]            in_lrd_we,
   input logic                         in_stall,
   input logic [`RN_IW*`RN_PRF_AW-1:0] out_prd,
   input logic                         rollback,
   input logic [`RN_CW-1:0]            cmt_fire,
   input logic [`RN_CW-1:0]            cmt_prd_we
);
   logic cmt_any;

   // Some lane frees a register this cycle
   assign cmt_any = |(cmt_fire & cmt_prd_we);

   // Free lists start half full
   a_stall_after_rst: assert property (@(posedge clk) $fell(rst) |-> !in_stall)
      else $error("in_stall high in the first cycle after reset");

   // Two writers never share a register
   a_prd_distinct: assert property (@(posedge clk) disable iff (rst)
      (in_lrd_we == '1 && !in_stall) |->
      (out_prd[`RN_PRF_AW-1:0] != out_prd[2*`RN_PRF_AW-1:`RN_PRF_AW]))
      else $error("both lanes were given the same physical register");

   // Frozen free list while stalled
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      (in_valid && in_stall && !rollback && !cmt_any) |=> $stable(out_prd))
      else $error("out_prd moved while the group was stalled");

endmodule

bind rn_top rn_asserts rn_asserts_i
(
   .clk        (clk),
   .rst        (rst),
   .in_valid   (in_valid),
   .in_lrd_we  (in_lrd_we),
   .in_stall   (in_stall),
   .out_prd    (out_prd),
   .rollback   (rollback),
   .cmt_fire   (cmt_fire),
   .cmt_prd_we (cmt_prd_we)
);

`default_nettype wire

// File: tests/tb_rn.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename stage testbench that plays the reorder buffer
// Table-driven rows and an LFSR mix against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

module tb_rn;
   import rn_pkg::*;

   localparam int N_ARF   = 1 << `RN_ARF_AW;
   localparam int N_DIR   = 25;
   localparam int N_RAND  = 300;
   localparam int N_ROWS  = N_DIR + N_RAND;
   localparam int RST_CYC = 16;
   // Row kinds
   localparam int K_REN = 0;
   localparam int K_CMT = 1;
   localparam int K_RB  = 2;
   localparam int K_RND = 3;
   // Stall column value that defers to the model
   localparam logic [1:0] ST_MODEL = 2'd2;

   logic                         clk;
   logic                         rst;
   logic                         in_valid;
   logic [`RN_IW-1:0]            in_lrd_we;
   logic [`RN_IW*`RN_ARF_AW-1:0] in_lrd;
   logic [`RN_IW*`RN_ARF_AW-1:0] in_lrs1;
   logic [`RN_IW*`RN_ARF_AW-1:0] in_lrs2;
   logic                         in_stall;
   logic [`RN_IW*`RN_PRF_AW-1:0] out_prd;
   logic [`RN_IW*`RN_PRF_AW-1:0] out_pfree;
   logic [`RN_IW*`RN_PRF_AW-1:0] out_prs1;
   logic [`RN_IW*`RN_PRF_AW-1:0] out_prs2;
   logic                         rollback;
   logic [`RN_CW-1:0]            cmt_fire;
   logic [`RN_CW-1:0]            cmt_prd_we;
   logic [`RN_CW*`RN_ARF_AW-1:0] cmt_lrd;
   logic [`RN_CW*`RN_PRF_AW-1:0] cmt_prd;
   logic [`RN_CW*`RN_PRF_AW-1:0] cmt_pfree;

   // Stimulus table
   int         t_kind  [N_ROWS];
   logic       t_valid [N_ROWS];
   lane_mask_t t_we    [N_ROWS];
   arf_idx_t   t_lrd   [N_ROWS][`RN_IW];
   arf_idx_t   t_lrs1  [N_ROWS][`RN_IW];
   arf_idx_t   t_lrs2  [N_ROWS][`RN_IW];
   int         t_ncmt  [N_ROWS];
   logic [1:0] t_stall [N_ROWS];
   int         n_rows;
   int         cur_row;

   // Reference model state
   prf_idx_t             m_rat  [N_ARF];
   prf_idx_t             m_arat [N_ARF];
   logic [`RN_N_PRF-1:0] m_fl;
   logic [`RN_N_PRF-1:0] m_afl;
   // In-flight writes with the oldest first
   arf_idx_t             q_lrd   [$];
   prf_idx_t             q_prd   [$];
   prf_idx_t             q_pfree [$];

   // Group on the wires this cycle
   logic       g_valid;
   lane_mask_t g_we;
   arf_idx_t   g_lrd  [`RN_IW];
   arf_idx_t   g_lrs1 [`RN_IW];
   arf_idx_t   g_lrs2 [`RN_IW];
   int         g_ncmt;
   logic       g_rb;
   logic       hold;
   logic [31:0] lfsr;

   rn_top rn_top_i (.*);

   always #2 clk = ~clk;

   // Galois LFSR x^32+x^22+x^2+x+1 stepped once per bit
   function automatic logic [31:0] rnd_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         end
      return v;
   endfunction

   function automatic logic [`RN_N_PRF-1:0] one_hot(int i);
      logic [`RN_N_PRF-1:0] v;
      v    = '0;
      v[i] = 1'b1;
      return v;
   endfunction

   // -1 when nothing is free
   function automatic int lowest_free(logic [`RN_N_PRF-1:0] v);
      for (int i = 0; i < `RN_N_PRF; i++)
         begin
            if (v[i])
               return i;
         end
      return -1;
   endfunction

   function automatic prf_idx_t lane_prf(logic [`RN_IW*`RN_PRF_AW-1:0] vec, int lane);
      return vec[lane*`RN_PRF_AW +: `RN_PRF_AW];
   endfunction

   task automatic fail_run();
      $display("sim failed");
      $fatal(1, "run stopped at row %0d", cur_row);
   endtask

   task automatic chk_prf(string name, int lane, prf_idx_t got, prf_idx_t exp);
      if (got !== exp)
         begin
            $display("ERR %s[%0d] got 0x%h exp 0x%h at row %0d", name, lane, got, exp, cur_row);
            fail_run();
         end
   endtask

   task automatic chk_stall(logic got, logic exp);
      if (got !== exp)
         begin
            $display("ERR in_stall got 0x%h exp 0x%h at row %0d", got, exp, cur_row);
            fail_run();
         end
   endtask

   // Arguments are kind, valid, writes, lrd, lrs1 and lrs2 per lane, commits and stall
   task automatic add_row(int k, int v, lane_mask_t we, int d0, int d1, int a0, int a1,
                          int b0, int b1, int nc, logic [1:0] st);
      t_kind[n_rows]    = k;
      t_valid[n_rows]   = (v != 0);
      t_we[n_rows]      = we;
      t_lrd[n_rows][0]  = arf_idx_t'(d0);
      t_lrd[n_rows][1]  = arf_idx_t'(d1);
      t_lrs1[n_rows][0] = arf_idx_t'(a0);
      t_lrs1[n_rows][1] = arf_idx_t'(a1);
      t_lrs2[n_rows][0] = arf_idx_t'(b0);
      t_lrs2[n_rows][1] = arf_idx_t'(b1);
      t_ncmt[n_rows]    = nc;
      t_stall[n_rows]   = st;
      n_rows++;
   endtask

   task automatic build_table();
      n_rows = 0;
      // Identity map out of reset gives writers 32 and 33
      add_row(K_REN, 1, 2'b11, 1, 2, 3, 5, 4, 6, 0, 2'd0);
      // Lane 1 sources and destination all hit lane 0's lrd
      add_row(K_REN, 1, 2'b11, 7, 7, 1, 7, 2, 7, 0, 2'd0);
      // Drain the rest of the free list
      for (int i = 0; i < 14; i++)
         add_row(K_REN, 1, 2'b11, 8 + i % 8, 16 + i % 8, i, i + 1, i + 2, i + 3, 0, 2'd0);
      // Empty list stalls the group and its held copy
      add_row(K_REN, 1, 2'b11, 9, 10, 1, 2, 3, 4, 0, 2'd1);
      add_row(K_REN, 1, 2'b11, 9, 10, 1, 2, 3, 4, 0, 2'd1);
      // Register 1 back alone still stalls two writers
      add_row(K_CMT, 0, 2'b00, 0, 0, 0, 0, 0, 0, 1, 2'd0);
      add_row(K_REN, 1, 2'b11, 9, 10, 1, 2, 3, 4, 0, 2'd1);
      // Register 2 back lets both lanes allocate
      add_row(K_CMT, 0, 2'b00, 0, 0, 0, 0, 0, 0, 1, 2'd0);
      add_row(K_REN, 1, 2'b11, 9, 10, 1, 2, 3, 4, 0, 2'd0);
      add_row(K_CMT, 0, 2'b00, 0, 0, 0, 0, 0, 0, 2, 2'd0);
      add_row(K_RB,  0, 2'b00, 0, 0, 0, 0, 0, 0, 0, 2'd0);
      // Committed mappings after rollback
      add_row(K_REN, 1, 2'b11, 3, 4, 1, 2, 7, 7, 0, 2'd0);
      for (int i = 0; i < N_RAND; i++)
         add_row(K_RND, 0, 2'b00, 0, 0, 0, 0, 0, 0, 0, ST_MODEL);
   endtask

   task automatic model_reset();
      for (int i = 0; i < N_ARF; i++)
         begin
            m_rat[i]  = prf_idx_t'(i);
            m_arat[i] = prf_idx_t'(i);
         end
      m_fl  = '0;
      for (int i = N_ARF; i < `RN_N_PRF; i++)
         m_fl[i] = 1'b1;
      m_afl = m_fl;
      hold  = 1'b0;
   endtask

   task automatic pick_group(int r);
      arf_idx_t msk;
      if (t_kind[r] == K_RND)
         begin
            // A stalled group stays on the wires
            if (!hold)
               begin
                  msk     = (rnd_bits(1) != 0) ? arf_idx_t'(3) : '1;
                  g_valid = (rnd_bits(2) != 0);
                  g_we    = lane_mask_t'(rnd_bits(2));
                  for (int j = 0; j < `RN_IW; j++)
                     begin
                        g_lrd[j]  = arf_idx_t'(rnd_bits(5)) & msk;
                        g_lrs1[j] = arf_idx_t'(rnd_bits(5)) & msk;
                        g_lrs2[j] = arf_idx_t'(rnd_bits(5)) & msk;
                     end
               end
            g_ncmt = int'(rnd_bits(2)) % 3;
            g_rb   = (rnd_bits(4) == 0);
         end
      else
         begin
            g_valid = t_valid[r];
            g_we    = t_we[r];
            g_lrd   = t_lrd[r];
            g_lrs1  = t_lrs1[r];
            g_lrs2  = t_lrs2[r];
            g_ncmt  = t_ncmt[r];
            g_rb    = (t_kind[r] == K_RB);
         end
      if (g_ncmt > q_lrd.size())
         g_ncmt = q_lrd.size();
   endtask

   task automatic drive_inputs();
      in_valid  = g_valid;
      in_lrd_we = g_we;
      in_lrd    = {g_lrd[1], g_lrd[0]};
      in_lrs1   = {g_lrs1[1], g_lrs1[0]};
      in_lrs2   = {g_lrs2[1], g_lrs2[0]};
      rollback  = g_rb;
      cmt_lrd   = '0;
      cmt_prd   = '0;
      cmt_pfree = '0;
      for (int k = 0; k < `RN_CW; k++)
         begin
            cmt_fire[k]   = (k < g_ncmt);
            cmt_prd_we[k] = (k < g_ncmt);
            if (k < g_ncmt)
               begin
                  cmt_lrd[k*`RN_ARF_AW +: `RN_ARF_AW]   = q_lrd[k];
                  cmt_prd[k*`RN_PRF_AW +: `RN_PRF_AW]   = q_prd[k];
                  cmt_pfree[k*`RN_PRF_AW +: `RN_PRF_AW] = q_pfree[k];
               end
         end
   endtask

   task automatic apply_row(int r);
      int                   p0;
      int                   p1;
      logic                 av0;
      logic                 av1;
      logic                 st;
      logic                 acc;
      logic                 byp1;
      logic                 byp2;
      logic                 bypd;
      prf_idx_t             e_prd   [`RN_IW];
      prf_idx_t             e_pfree [`RN_IW];
      prf_idx_t             old_arat [N_ARF];
      logic [`RN_N_PRF-1:0] old_afl;
      cur_row = r;
      pick_group(r);
      @(negedge clk);
      drive_inputs();
      #1;
      // Lowest free register and the next lowest
      p0       = lowest_free(m_fl);
      p1       = (p0 < 0) ? -1 : lowest_free(m_fl & ~one_hot(p0));
      av0      = (p0 >= 0);
      av1      = (p1 >= 0);
      e_prd[0] = prf_idx_t'(p0);
      e_prd[1] = prf_idx_t'(p1);
      st       = (g_we[0] && !av0) || (g_we[1] && !av1);
      chk_stall(in_stall, (t_stall[r] == ST_MODEL) ? st : t_stall[r][0]);
      if (av0)
         chk_prf("out_prd", 0, lane_prf(out_prd, 0), e_prd[0]);
      if (av1)
         chk_prf("out_prd", 1, lane_prf(out_prd, 1), e_prd[1]);
      // Lane 1 sees lane 0's new register
      byp1       = g_we[0] && (g_lrs1[1] == g_lrd[0]);
      byp2       = g_we[0] && (g_lrs2[1] == g_lrd[0]);
      bypd       = g_we[0] && (g_lrd[1] == g_lrd[0]);
      e_pfree[0] = m_rat[g_lrd[0]];
      e_pfree[1] = bypd ? e_prd[0] : m_rat[g_lrd[1]];
      chk_prf("out_prs1", 0, lane_prf(out_prs1, 0), m_rat[g_lrs1[0]]);
      chk_prf("out_prs2", 0, lane_prf(out_prs2, 0), m_rat[g_lrs2[0]]);
      chk_prf("out_pfree", 0, lane_prf(out_pfree, 0), e_pfree[0]);
      if (!byp1 || av0)
         chk_prf("out_prs1", 1, lane_prf(out_prs1, 1), byp1 ? e_prd[0] : m_rat[g_lrs1[1]]);
      if (!byp2 || av0)
         chk_prf("out_prs2", 1, lane_prf(out_prs2, 1), byp2 ? e_prd[0] : m_rat[g_lrs2[1]]);
      if (!bypd || av0)
         chk_prf("out_pfree", 1, lane_prf(out_pfree, 1), e_pfree[1]);

      // State after the coming edge
      acc      = g_valid && !st && !g_rb;
      old_arat = m_arat;
      old_afl  = m_afl;
      for (int k = 0; k < g_ncmt; k++)
         begin
            m_arat[q_lrd[0]] = q_prd[0];
            m_afl = (m_afl & ~one_hot(q_prd[0])) | one_hot(q_pfree[0]);
            m_fl  = m_fl | one_hot(q_pfree[0]);
            void'(q_lrd.pop_front());
            void'(q_prd.pop_front());
            void'(q_pfree.pop_front());
         end
      for (int j = 0; j < `RN_IW; j++)
         begin
            if (acc && g_we[j])
               begin
                  m_fl = m_fl & ~one_hot(e_prd[j]);
                  m_rat[g_lrd[j]] = e_prd[j];
                  q_lrd.push_back(g_lrd[j]);
                  q_prd.push_back(e_prd[j]);
                  q_pfree.push_back(e_pfree[j]);
               end
         end
      // Committed copies as they stood before this edge
      if (g_rb)
         begin
            m_rat = old_arat;
            m_fl  = old_afl;
            q_lrd.delete();
            q_prd.delete();
            q_pfree.delete();
         end
      hold = (t_kind[r] == K_RND) && g_valid && st && !g_rb;
   endtask

   initial
      begin
         clk        = 1'b0;
         rst        = 1'b1;
         in_valid   = 1'b0;
         in_lrd_we  = '1;
         in_lrd     = '0;
         in_lrs1    = '0;
         in_lrs2    = '0;
         rollback   = 1'b0;
         cmt_fire   = '0;
         cmt_prd_we = '0;
         cmt_lrd    = '0;
         cmt_prd    = '0;
         cmt_pfree  = '0;
         cur_row    = -1;
         lfsr       = 32'h7376;
         build_table();
         model_reset();
         repeat (RST_CYC) @(posedge clk);
         @(negedge clk);
         rst = 1'b0;
         for (int r = 0; r < n_rows; r++)
            apply_row(r);
         @(negedge clk);
         in_valid = 1'b0;
         rollback = 1'b0;
         cmt_fire = '0;
         $display("sim passed");
         $finish;
      end

   // Ten cycles per row plus reset
   initial
      begin
         #((N_ROWS * 10 + RST_CYC) * 4);
         $display("watchdog expired before all rows were applied");
         fail_run();
      end

endmodule

`default_nettype wire

// File: rename_unit.f
+incdir+verilog
verilog/rn_pkg.sv
verilog/rn_cmt_if.sv
verilog/prio_enc_gs.sv
verilog/rn_fl.sv
verilog/rn_rat.sv
verilog/rn_top.sv
tests/rn_asserts.sv
tests/tb_rn.sv

// File: run_sim.sh
#!/bin/sh
# Build the rename stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_rn \
   -f rename_unit.f \
   -o tb_rn
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/tb_rn
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation ended with status $status"
   exit "$status"
fi

exit 0
